// File: design/axi_mem_top.sv
module axi_mem_top
    import mem_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  aw_valid_i,
    input  logic [ID_WIDTH-1:0]   aw_id_i,
    input  logic [ADDR_WIDTH-1:0] aw_addr_i,
    input  logic [LEN_WIDTH-1:0]  aw_len_i,
    input  logic [1:0]            aw_burst_i,
    output logic                  aw_ready_o,
    input  logic                  w_valid_i,
    input  logic [DATA_WIDTH-1:0] w_data_i,
    input  logic [STRB_WIDTH-1:0] w_strb_i,
    input  logic                  w_last_i,
    output logic                  w_ready_o,
    output logic                  b_valid_o,
    output logic [ID_WIDTH-1:0]   b_id_o,
    output logic [1:0]            b_resp_o,
    input  logic                  b_ready_i,
    input  logic                  ar_valid_i,
    input  logic [ID_WIDTH-1:0]   ar_id_i,
    input  logic [ADDR_WIDTH-1:0] ar_addr_i,
    input  logic [LEN_WIDTH-1:0]  ar_len_i,
    input  logic [1:0]            ar_burst_i,
    output logic                  ar_ready_o,
    output logic                  r_valid_o,
    output logic [ID_WIDTH-1:0]   r_id_o,
    output logic [DATA_WIDTH-1:0] r_data_o,
    output logic [1:0]            r_resp_o,
    output logic                  r_last_o,
    input  logic                  r_ready_i
);

    logic                       wr_req;
    logic                       wr_gnt;
    logic [WORD_ADDR_WIDTH-1:0] wr_addr;
    logic [DATA_WIDTH-1:0]      wr_data;
    logic [STRB_WIDTH-1:0]      wr_strb;
    logic                       rd_req;
    logic                       rd_gnt;
    logic [WORD_ADDR_WIDTH-1:0] rd_addr;
    logic                       rd_data_valid;
    logic [DATA_WIDTH-1:0]      rd_data;
    logic                       sram_en;
    logic                       sram_we;
    logic [WORD_ADDR_WIDTH-1:0] sram_addr;
    logic [DATA_WIDTH-1:0]      sram_wdata;
    logic [STRB_WIDTH-1:0]      sram_strb;
    logic [DATA_WIDTH-1:0]      sram_rdata;

    axi_write_engine axi_write_engine_i (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .aw_valid_i (aw_valid_i),
        .aw_id_i    (aw_id_i),
        .aw_addr_i  (aw_addr_i),
        .aw_len_i   (aw_len_i),
        .aw_burst_i (aw_burst_i),
        .w_valid_i  (w_valid_i),
        .w_data_i   (w_data_i),
        .w_strb_i   (w_strb_i),
        .w_last_i   (w_last_i),
        .b_ready_i  (b_ready_i),
        .wr_gnt_i   (wr_gnt),
        .aw_ready_o (aw_ready_o),
        .w_ready_o  (w_ready_o),
        .b_valid_o  (b_valid_o),
        .b_id_o     (b_id_o),
        .b_resp_o   (b_resp_o),
        .wr_req_o   (wr_req),
        .wr_addr_o  (wr_addr),
        .wr_data_o  (wr_data),
        .wr_strb_o  (wr_strb)
    );

    axi_read_engine axi_read_engine_i (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .ar_valid_i      (ar_valid_i),
        .ar_id_i         (ar_id_i),
        .ar_addr_i       (ar_addr_i),
        .ar_len_i        (ar_len_i),
        .ar_burst_i      (ar_burst_i),
        .r_ready_i       (r_ready_i),
        .rd_gnt_i        (rd_gnt),
        .rd_data_valid_i (rd_data_valid),
        .rd_data_i       (rd_data),
        .ar_ready_o      (ar_ready_o),
        .r_valid_o       (r_valid_o),
        .r_id_o          (r_id_o),
        .r_data_o        (r_data_o),
        .r_resp_o        (r_resp_o),
        .r_last_o        (r_last_o),
        .rd_req_o        (rd_req),
        .rd_addr_o       (rd_addr)
    );

    mem_port_arbiter mem_port_arbiter_i (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .wr_req_i        (wr_req),
        .wr_addr_i       (wr_addr),
        .wr_data_i       (wr_data),
        .wr_strb_i       (wr_strb),
        .rd_req_i        (rd_req),
        .rd_addr_i       (rd_addr),
        .sram_rdata_i    (sram_rdata),
        .wr_gnt_o        (wr_gnt),
        .rd_gnt_o        (rd_gnt),
        .rd_data_valid_o (rd_data_valid),
        .rd_data_o       (rd_data),
        .sram_en_o       (sram_en),
        .sram_we_o       (sram_we),
        .sram_addr_o     (sram_addr),
        .sram_wdata_o    (sram_wdata),
        .sram_strb_o     (sram_strb)
    );

    sram_bank sram_bank_i (
        .clk_i        (clk_i),
        .sram_en_i    (sram_en),
        .sram_we_i    (sram_we),
        .sram_addr_i  (sram_addr),
        .sram_wdata_i (sram_wdata),
        .sram_strb_i  (sram_strb),
        .sram_rdata_o (sram_rdata)
    );

endmodule

// File: design/axi_read_engine.sv
module axi_read_engine
    import mem_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       ar_valid_i,
    input  logic [ID_WIDTH-1:0]        ar_id_i,
    input  logic [ADDR_WIDTH-1:0]      ar_addr_i,
    input  logic [LEN_WIDTH-1:0]       ar_len_i,
    input  logic [1:0]                 ar_burst_i,
    input  logic                       r_ready_i,
    input  logic                       rd_gnt_i,
    input  logic                       rd_data_valid_i,
    input  logic [DATA_WIDTH-1:0]      rd_data_i,
    output logic                       ar_ready_o,
    output logic                       r_valid_o,
    output logic [ID_WIDTH-1:0]        r_id_o,
    output logic [DATA_WIDTH-1:0]      r_data_o,
    output logic [1:0]                 r_resp_o,
    output logic                       r_last_o,
    output logic                       rd_req_o,
    output logic [WORD_ADDR_WIDTH-1:0] rd_addr_o
);

    logic                  init_q;
    logic                  busy_q;
    logic                  inflight_q;  // a beat was issued last cycle and lands now
    logic                  inflight_err_q;
    logic                  out_valid_q;
    logic                  out_err_q;
    logic [DATA_WIDTH-1:0] out_data_q;
    logic [ID_WIDTH-1:0]   id_q;
    logic [ADDR_WIDTH-3:0] addr_q;
    logic [ADDR_WIDTH-3:0] addr_next;
    logic [LEN_WIDTH-1:0]  len_q;
    logic [1:0]            burst_q;
    logic [LEN_WIDTH:0]    issue_cnt_q;
    logic [LEN_WIDTH-1:0]  ret_cnt_q;
    logic                  beat_oor;
    logic                  slot_free;
    logic                  issue;
    logic                  arrive;
    logic                  ar_fire;
    logic                  r_fire;

    always_comb begin
        case (burst_q)
            BURST_FIXED: addr_next = addr_q;
            BURST_INCR:  addr_next = addr_q + 1'b1;
            default:     addr_next = addr_q + 1'b1;
        endcase
    end

    assign beat_oor = addr_q >= MEM_WORDS;
    // the output register must be free by the time the result comes back
    assign slot_free = busy_q && (issue_cnt_q <= {1'b0, len_q}) && !inflight_q &&
                       (!out_valid_q || r_ready_i);
    assign issue     = slot_free && (beat_oor || rd_gnt_i);
    assign arrive    = inflight_q && (inflight_err_q || rd_data_valid_i);

    assign rd_req_o  = slot_free && !beat_oor;
    assign rd_addr_o = addr_q[WORD_ADDR_WIDTH-1:0];

    assign ar_ready_o = init_q && !busy_q;
    assign r_valid_o  = out_valid_q;
    assign r_id_o     = id_q;
    assign r_data_o   = out_data_q;
    assign r_resp_o   = out_err_q ? RESP_SLVERR : RESP_OKAY;
    assign r_last_o   = out_valid_q && (ret_cnt_q == len_q);

    assign ar_fire = ar_valid_i && ar_ready_o;
    assign r_fire  = r_valid_o && r_ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            init_q      <= 1'b0;
            busy_q      <= 1'b0;
            inflight_q  <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            init_q     <= 1'b1;
            inflight_q <= issue;
            if (ar_fire) begin
                busy_q <= 1'b1;
            end else if (r_fire && r_last_o) begin
                busy_q <= 1'b0;
            end
            if (arrive) begin
                out_valid_q <= 1'b1;
            end else if (r_fire) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ar_fire) begin
            id_q        <= ar_id_i;
            addr_q      <= ar_addr_i[ADDR_WIDTH-1:2];
            len_q       <= ar_len_i;
            burst_q     <= ar_burst_i;
            issue_cnt_q <= '0;
            ret_cnt_q   <= '0;
        end else begin
            if (issue) begin
                addr_q      <= addr_next;
                issue_cnt_q <= issue_cnt_q + 1'b1;
            end
            if (r_fire) begin
                ret_cnt_q <= ret_cnt_q + 1'b1;
            end
        end
        if (issue) begin
            inflight_err_q <= beat_oor;
        end
        if (arrive) begin
            out_data_q <= inflight_err_q ? '0 : rd_data_i;  // out-of-range beats read as zero
            out_err_q  <= inflight_err_q;
        end
    end

endmodule

// File: design/axi_write_engine.sv
module axi_write_engine
    import mem_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       aw_valid_i,
    input  logic [ID_WIDTH-1:0]        aw_id_i,
    input  logic [ADDR_WIDTH-1:0]      aw_addr_i,
    input  logic [LEN_WIDTH-1:0]       aw_len_i,
    input  logic [1:0]                 aw_burst_i,
    input  logic                       w_valid_i,
    input  logic [DATA_WIDTH-1:0]      w_data_i,
    input  logic [STRB_WIDTH-1:0]      w_strb_i,
    input  logic                       w_last_i,
    input  logic                       b_ready_i,
    input  logic                       wr_gnt_i,
    output logic                       aw_ready_o,
    output logic                       w_ready_o,
    output logic                       b_valid_o,
    output logic [ID_WIDTH-1:0]        b_id_o,
    output logic [1:0]                 b_resp_o,
    output logic                       wr_req_o,
    output logic [WORD_ADDR_WIDTH-1:0] wr_addr_o,
    output logic [DATA_WIDTH-1:0]      wr_data_o,
    output logic [STRB_WIDTH-1:0]      wr_strb_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_DATA,
        S_RESP
    } state_t;

    state_t                state_q;
    logic                  init_q;
    logic                  err_q;
    logic [ID_WIDTH-1:0]   id_q;
    logic [ADDR_WIDTH-3:0] addr_q;  // word address, wide enough to see past the storage
    logic [ADDR_WIDTH-3:0] addr_next;
    logic [LEN_WIDTH-1:0]  len_q;
    logic [LEN_WIDTH-1:0]  beat_cnt_q;
    logic [1:0]            burst_q;
    logic                  beat_oor;
    logic                  last_beat;
    logic                  aw_fire;
    logic                  w_fire;
    logic                  b_fire;

    assign beat_oor  = addr_q >= MEM_WORDS;
    assign last_beat = beat_cnt_q == len_q;

    always_comb begin
        case (burst_q)
            BURST_FIXED: addr_next = addr_q;
            BURST_INCR:  addr_next = addr_q + 1'b1;
            default:     addr_next = addr_q + 1'b1;  // wrap steps like incr
        endcase
    end

    assign aw_ready_o = init_q && (state_q == S_IDLE);
    // in-range beats wait for the bank, dropped beats go one per cycle
    assign w_ready_o  = (state_q == S_DATA) && (beat_oor || wr_gnt_i);
    assign b_valid_o  = state_q == S_RESP;
    assign b_id_o     = id_q;
    assign b_resp_o   = err_q ? RESP_SLVERR : RESP_OKAY;

    assign wr_req_o  = (state_q == S_DATA) && w_valid_i && !beat_oor;
    assign wr_addr_o = addr_q[WORD_ADDR_WIDTH-1:0];
    assign wr_data_o = w_data_i;
    assign wr_strb_o = w_strb_i;

    assign aw_fire = aw_valid_i && aw_ready_o;
    assign w_fire  = w_valid_i && w_ready_o;
    assign b_fire  = b_valid_o && b_ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= S_IDLE;
            init_q  <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            init_q <= 1'b1;  // holds the ready outputs low for one cycle after reset
            case (state_q)
                S_IDLE: begin
                    if (aw_fire) begin
                        state_q <= S_DATA;
                        err_q   <= 1'b0;
                    end
                end
                S_DATA: begin
                    if (w_fire) begin
                        // a misplaced wlast is reported like an out-of-range beat
                        if (beat_oor || (w_last_i != last_beat)) begin
                            err_q <= 1'b1;
                        end
                        if (last_beat) begin
                            state_q <= S_RESP;
                        end
                    end
                end
                S_RESP: begin
                    if (b_fire) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (aw_fire) begin
            id_q       <= aw_id_i;
            addr_q     <= aw_addr_i[ADDR_WIDTH-1:2];
            len_q      <= aw_len_i;
            burst_q    <= aw_burst_i;
            beat_cnt_q <= '0;
        end else if (w_fire) begin
            addr_q     <= addr_next;
            beat_cnt_q <= beat_cnt_q + 1'b1;
        end
    end

endmodule

// File: design/mem_pkg.sv
package mem_pkg;

    localparam int ID_WIDTH        = 4;
    localparam int ADDR_WIDTH      = 16;  // byte address
    localparam int DATA_WIDTH      = 32;
    localparam int STRB_WIDTH      = DATA_WIDTH / 8;
    localparam int LEN_WIDTH       = 4;   // beats minus one

    localparam int MEM_WORDS       = 1024;
    localparam int WORD_ADDR_WIDTH = 10;

    // only fixed and incr are decoded, wrap falls through to incr
    localparam logic [1:0] BURST_FIXED = 2'd0;
    localparam logic [1:0] BURST_INCR  = 2'd1;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

endpackage

// File: design/mem_port_arbiter.sv
module mem_port_arbiter
    import mem_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       wr_req_i,
    input  logic [WORD_ADDR_WIDTH-1:0] wr_addr_i,
    input  logic [DATA_WIDTH-1:0]      wr_data_i,
    input  logic [STRB_WIDTH-1:0]      wr_strb_i,
    input  logic                       rd_req_i,
    input  logic [WORD_ADDR_WIDTH-1:0] rd_addr_i,
    input  logic [DATA_WIDTH-1:0]      sram_rdata_i,
    output logic                       wr_gnt_o,
    output logic                       rd_gnt_o,
    output logic                       rd_data_valid_o,
    output logic [DATA_WIDTH-1:0]      rd_data_o,
    output logic                       sram_en_o,
    output logic                       sram_we_o,
    output logic [WORD_ADDR_WIDTH-1:0] sram_addr_o,
    output logic [DATA_WIDTH-1:0]      sram_wdata_o,
    output logic [STRB_WIDTH-1:0]      sram_strb_o
);

    logic last_rd_q;  // set when the read engine won the most recent grant
    logic rd_pend_q;

    // on a tie the engine that did not win last time gets the port
    assign wr_gnt_o = wr_req_i && (!rd_req_i || last_rd_q);
    assign rd_gnt_o = rd_req_i && !wr_gnt_o;

    assign sram_en_o    = wr_gnt_o || rd_gnt_o;
    assign sram_we_o    = wr_gnt_o;
    assign sram_addr_o  = wr_gnt_o ? wr_addr_i : rd_addr_i;
    assign sram_wdata_o = wr_data_i;
    assign sram_strb_o  = wr_strb_i;

    assign rd_data_valid_o = rd_pend_q;
    assign rd_data_o       = sram_rdata_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            last_rd_q <= 1'b0;
            rd_pend_q <= 1'b0;
        end else begin
            if (wr_gnt_o) begin
                last_rd_q <= 1'b0;
            end else if (rd_gnt_o) begin
                last_rd_q <= 1'b1;
            end
            rd_pend_q <= rd_gnt_o;  // bank data is registered, so mark it a cycle later
        end
    end

endmodule

// File: design/sram_bank.sv
module sram_bank
    import mem_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       sram_en_i,
    input  logic                       sram_we_i,
    input  logic [WORD_ADDR_WIDTH-1:0] sram_addr_i,
    input  logic [DATA_WIDTH-1:0]      sram_wdata_i,
    input  logic [STRB_WIDTH-1:0]      sram_strb_i,
    output logic [DATA_WIDTH-1:0]      sram_rdata_o
);

    logic [DATA_WIDTH-1:0] mem_q [MEM_WORDS];

    always_ff @(posedge clk_i) begin
        if (sram_en_i) begin
            if (sram_we_i) begin
                for (int i = 0; i < STRB_WIDTH; i++) begin
                    if (sram_strb_i[i]) begin
                        mem_q[sram_addr_i][8*i +: 8] <= sram_wdata_i[8*i +: 8];
                    end
                end
            end else begin
                sram_rdata_o <= mem_q[sram_addr_i];  // data shows up one cycle after the enable
            end
        end
    end

endmodule

// File: files.f
design/mem_pkg.sv
design/sram_bank.sv
design/mem_port_arbiter.sv
design/axi_write_engine.sv
design/axi_read_engine.sv
design/axi_mem_top.sv
tests/axi_mem_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module axi_mem_tb \
    -f files.f \
    -o axi_mem_sim

# the simulator exits non-zero on a fatal check, the log search below decides the result
./obj_dir/axi_mem_sim 2>&1 | tee sim.log

if grep -qx "Testbench passed" sim.log; then
    exit 0
fi
exit 1

// File: tests/axi_mem_tb.sv
module axi_mem_tb;

    logic clk_i = 1'b0, reset_i = 1'b1;
    logic aw_valid_i = 1'b0, w_valid_i = 1'b0, w_last_i = 1'b0, b_ready_i = 1'b0;
    logic ar_valid_i = 1'b0, r_ready_i = 1'b0;
    logic [3:0] aw_id_i = '0, aw_len_i = '0, ar_id_i = '0, ar_len_i = '0, w_strb_i = '0;
    logic [15:0] aw_addr_i = '0, ar_addr_i = '0;
    logic [1:0] aw_burst_i = '0, ar_burst_i = '0;
    logic [31:0] w_data_i = '0;
    logic aw_ready_o, w_ready_o, b_valid_o, ar_ready_o, r_valid_o, r_last_o;
    logic [3:0] b_id_o, r_id_o;
    logic [1:0] b_resp_o, r_resp_o;
    logic [31:0] r_data_o;

    integer seed = 32'h631247e2;
    integer fd, n_lines = 0;
    logic [8*16-1:0] wr_name, rd_name;
    logic [31:0] wr_id, wr_addr, wr_len, wr_burst, wr_par, wr_bresp;
    logic [31:0] rd_id, rd_addr, rd_len, rd_burst, rd_par;
    logic [31:0] wr_beat_data [16], wr_beat_strb [16], rd_beat_data [16], rd_beat_resp [16];

    axi_mem_top axi_mem_top_i (.*);

    always #2 clk_i = ~clk_i;

    always @(negedge clk_i) begin
        r_ready_i = ($random(seed) & 3) != 0;  // low on about one cycle in four
        b_ready_i = ($random(seed) & 3) != 0;
    end

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %0s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic read_entry(output logic [31:0] data, output logic [31:0] field);
        if ($fscanf(fd, "%h %h", data, field) != 2) begin
            $display("the vector file ends in the middle of a burst");
            abort_run();
        end
    endtask

    task automatic load_write();
        if ($fscanf(fd, "%s %h %h %h %h %h %h", wr_name, wr_id, wr_addr, wr_len, wr_burst,
                    wr_par, wr_bresp) != 7) begin
            $display("a write header in the vector file is malformed");
            abort_run();
        end
        for (int beat = 0; beat <= wr_len; beat++) begin
            read_entry(wr_beat_data[beat], wr_beat_strb[beat]);
        end
    endtask

    task automatic load_read();
        if ($fscanf(fd, "%s %h %h %h %h %h", rd_name, rd_id, rd_addr, rd_len, rd_burst,
                    rd_par) != 6) begin
            $display("a read header in the vector file is malformed");
            abort_run();
        end
        for (int beat = 0; beat <= rd_len; beat++) begin
            read_entry(rd_beat_data[beat], rd_beat_resp[beat]);
        end
    endtask

    task automatic expect_kind(input logic [31:0] want);
        logic [31:0] next_kind;
        if ($fscanf(fd, "%s", next_kind) != 1 || next_kind != want) begin
            $display("a parallel entry is not followed by an entry of the other kind");
            abort_run();
        end
    endtask

    // starts and ends on a falling edge, samples 1 unit later when everything has settled
    task automatic run_write();
        aw_valid_i = 1'b1;
        aw_id_i    = wr_id[3:0];
        aw_addr_i  = wr_addr[15:0];
        aw_len_i   = wr_len[3:0];
        aw_burst_i = wr_burst[1:0];
        #1;
        while (!aw_ready_o) begin
            @(negedge clk_i);
            #1;
        end
        @(negedge clk_i);
        aw_valid_i = 1'b0;
        for (int beat = 0; beat <= wr_len; beat++) begin
            w_valid_i = 1'b1;
            w_data_i  = wr_beat_data[beat];
            w_strb_i  = wr_beat_strb[beat][3:0];
            w_last_i  = beat == wr_len;
            #1;
            while (!w_ready_o) begin
                @(negedge clk_i);
                #1;
            end
            @(negedge clk_i);
        end
        w_valid_i = 1'b0;
        w_last_i  = 1'b0;
        #1;
        while (!(b_valid_o && b_ready_i)) begin
            @(negedge clk_i);
            #1;
        end
        check($sformatf("%0s bid", wr_name), wr_id, 32'(b_id_o));
        check($sformatf("%0s bresp", wr_name), wr_bresp, 32'(b_resp_o));
        @(negedge clk_i);
    endtask

    task automatic run_read();
        ar_valid_i = 1'b1;
        ar_id_i    = rd_id[3:0];
        ar_addr_i  = rd_addr[15:0];
        ar_len_i   = rd_len[3:0];
        ar_burst_i = rd_burst[1:0];
        #1;
        while (!ar_ready_o) begin
            @(negedge clk_i);
            #1;
        end
        @(negedge clk_i);
        ar_valid_i = 1'b0;
        for (int beat = 0; beat <= rd_len; beat++) begin
            #1;
            while (!(r_valid_o && r_ready_i)) begin
                @(negedge clk_i);
                #1;
            end
            check($sformatf("%0s rdata[%0d]", rd_name, beat), rd_beat_data[beat], r_data_o);
            check($sformatf("%0s rresp[%0d]", rd_name, beat), rd_beat_resp[beat], 32'(r_resp_o));
            check($sformatf("%0s rid[%0d]", rd_name, beat), rd_id, 32'(r_id_o));
            check($sformatf("%0s rlast[%0d]", rd_name, beat), 32'(beat == rd_len), 32'(r_last_o));
            @(negedge clk_i);
        end
        #1;
        check($sformatf("%0s extra beat", rd_name), 32'd0, 32'(r_valid_o));
    endtask

    // both bursts are offered on the same falling edge
    task automatic run_parallel();
        @(negedge clk_i);
        fork
            run_write();
            run_read();
        join
    endtask

    initial begin
        wait (n_lines != 0);
        repeat (200 * n_lines) @(posedge clk_i);
        $display("the run timed out after %0d cycles", 200 * n_lines);
        abort_run();
    end

    initial begin
        logic [8*4-1:0]   kind;
        logic [8*200-1:0] line_buf;
        bit               done;
        done = 1'b0;
        fd = $fopen("tests/axi_mem_vectors.txt", "r");
        if (fd == 0) begin
            $display("the vector file could not be opened");
            abort_run();
        end
        while ($fgets(line_buf, fd) != 0) begin
            n_lines++;
        end
        $fclose(fd);
        fd = $fopen("tests/axi_mem_vectors.txt", "r");
        repeat (4) @(negedge clk_i);
        reset_i = 1'b0;
        #1;
        // all valid and ready outputs stay low for one cycle after reset
        check("reset", 32'd0, {27'd0, aw_ready_o, ar_ready_o, w_ready_o, r_valid_o, b_valid_o});
        while (!done) begin
            if ($fscanf(fd, "%s", kind) != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                void'($fgets(line_buf, fd));
            end else if (kind == "W") begin
                load_write();
                if (wr_par != 0) begin
                    expect_kind("R");
                    load_read();
                    run_parallel();
                end else begin
                    @(negedge clk_i);
                    run_write();
                end
            end else if (kind == "R") begin
                load_read();
                if (rd_par != 0) begin
                    expect_kind("W");
                    load_write();
                    run_parallel();
                end else begin
                    @(negedge clk_i);
                    run_read();
                end
            end else begin
                $display("the vector file holds an unknown entry kind");
                abort_run();
            end
        end
        $fclose(fd);
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: tests/axi_mem_vectors.txt
# W name id addr len burst par bresp, then len+1 beats of: data strb
# R name id addr len burst par, then len+1 beats of: data resp (par 1 starts it with the next entry)
W single 3 0010 0 1 0 0
11223344 f
R single 3 0010 0 1 0
11223344 0
W fill 5 0100 7 1 0 0
aaaaaaa0 f aaaaaaa1 f aaaaaaa2 f aaaaaaa3 f
aaaaaaa4 f aaaaaaa5 f aaaaaaa6 f aaaaaaa7 f
W strobe 6 0100 7 1 0 0
55555550 1 55555551 2 55555552 4 55555553 8
55555554 3 55555555 c 55555556 5 55555557 a
R strobe_rd 7 0100 7 1 0
aaaaaa50 0 aaaa55a1 0 aa55aaa2 0 55aaaaa3 0
aaaa5554 0 5555aaa5 0 aa55aa56 0 55aa55a7 0
W fixed 9 0020 3 0 0 0
01020304 f 11111111 3 22222222 4 33333333 8
R fixed_rd 9 0020 1 0 0
33221111 0 33221111 0
W cross 2 0ff8 3 1 0 2
cafe0000 f cafe0001 f cafe0002 f cafe0003 f
R cross_rd 2 0ff8 3 1 0
cafe0000 0 cafe0001 0 00000000 2 00000000 2
W par_wr c 0400 3 1 1 0
600d0000 f 600d0001 f 600d0002 f 600d0003 f
R par_rd d 0100 7 1 0
aaaaaa50 0 aaaa55a1 0 aa55aaa2 0 55aaaaa3 0
aaaa5554 0 5555aaa5 0 aa55aa56 0 55aa55a7 0
R par_chk e 0400 3 1 0
600d0000 0 600d0001 0 600d0002 0 600d0003 0
